/* sim.f */
logic/dg_pkg.sv
logic/neighbor_link.sv
logic/processing_unit.sv
logic/stage_controller.sv
logic/decoding_graph.sv
bench/tb_decoding_graph_asserts.sv
bench/tb_decoding_graph.sv

/* Makefile */
SIM       := verilator
TOP       := tb_decoding_graph
FILELIST  := sim.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS := +verilator+error+limit+100
PASS_TEXT := test passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_decoding_graph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decoding_graph;

    localparam int GX         = 4;
    localparam int GZ         = 2;
    localparam int GU         = 2;
    localparam int MAX_WEIGHT = 2;
    localparam int AW         = 4;  // round bit, two row bits, column bit
    localparam int PER_ROUND  = GX * GZ;
    localparam int UNITS      = PER_ROUND * GU;
    localparam int TIMEOUT    = 1000;

    logic                 clk = 1'b0;
    logic                 rst_i;
    logic [PER_ROUND-1:0] measurements_i;
    logic                 meas_req_i;
    logic                 dec_req_i;
    logic                 meas_ack_o;
    logic                 dec_ack_o;
    logic [UNITS-1:0]     odd_clusters_o;
    logic [UNITS-1:0]     busy_o;
    logic [AW*UNITS-1:0]  roots_o;

    logic [UNITS-1:0] ref_meas;  // defects per unit with round 1 on top
    logic [UNITS-1:0] exp_odd;
    int               exp_root [UNITS];
    int               growth [UNITS][6];  // internal links mirrored on both ends

    decoding_graph #(
        .GRID_WIDTH_X (GX),
        .GRID_WIDTH_Z (GZ),
        .GRID_WIDTH_U (GU),
        .MAX_WEIGHT   (MAX_WEIGHT)
    ) UUT (.*);

    always #5 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;  // outputs settled and inputs may change
    endtask

    function automatic int root_of(input int u);
        return int'(roots_o[u*AW +: AW]);
    endfunction

    // unit next to u in direction d (north, south, west, east, down, up) or -1 off grid
    function automatic int peer_of(input int u, input int d);
        int k;
        int i;
        int j;
        k = u / PER_ROUND;
        i = (u / GZ) % GX;
        j = u % GZ;
        case (d)
            0: i = i - 1;
            1: i = i + 1;
            2: j = j - 1;
            3: j = j + 1;
            4: k = k - 1;
            default: k = k + 1;
        endcase
        if (k < 0 || k >= GU || i < 0 || i >= GX || j < 0 || j >= GZ) begin
            return -1;
        end
        return k * PER_ROUND + i * GZ + j;  // equals the address on this grid
    endfunction

    function automatic bit on_boundary(input int u, input int d);
        return peer_of(u, d) < 0 && d != 2 && d != 3 && d != 5;  // no east, west or up edge
    endfunction

    function automatic void form_clusters();
        bit par [UNITS];
        bit bnd [UNITS];
        int p;
        for (int u = 0; u < UNITS; u++) begin
            exp_root[u] = u;
            par[u] = 1'b0;
            bnd[u] = 1'b0;
        end
        repeat (UNITS) begin  // lowest address floods each cluster over full links
            for (int u = 0; u < UNITS; u++) begin
                for (int d = 0; d < 6; d++) begin
                    p = peer_of(u, d);
                    if (p >= 0 && growth[u][d] == MAX_WEIGHT && exp_root[p] < exp_root[u]) begin
                        exp_root[u] = exp_root[p];
                    end
                end
            end
        end
        for (int u = 0; u < UNITS; u++) begin
            par[exp_root[u]] = par[exp_root[u]] ^ ref_meas[u];
            for (int d = 0; d < 6; d++) begin
                if (on_boundary(u, d) && growth[u][d] == MAX_WEIGHT) begin
                    bnd[exp_root[u]] = 1'b1;  // cluster reached the code edge
                end
            end
        end
        for (int u = 0; u < UNITS; u++) begin
            exp_odd[u] = par[exp_root[u]] & ~bnd[exp_root[u]];
        end
    endfunction

    task automatic model_decode();
        int p;
        for (int u = 0; u < UNITS; u++) begin
            for (int d = 0; d < 6; d++) begin
                growth[u][d] = 0;
            end
        end
        form_clusters();
        repeat (4 * UNITS) begin
            if (exp_odd != '0) begin
                // every unit of an odd cluster pushes one unit into each of its links
                for (int u = 0; u < UNITS; u++) begin
                    for (int d = 0; d < 6; d++) begin
                        p = peer_of(u, d);
                        if (exp_odd[u] && (p >= 0 || on_boundary(u, d))
                                && growth[u][d] < MAX_WEIGHT) begin
                            growth[u][d]++;
                            if (p >= 0) begin
                                growth[p][d ^ 1] = growth[u][d];
                            end
                        end
                    end
                end
                form_clusters();
            end
        end
    endtask

    function automatic void expect_singletons();
        for (int u = 0; u < UNITS; u++) begin
            exp_root[u] = u;
        end
        exp_odd = ref_meas;  // each defect alone is odd
    endfunction

    task automatic check_outputs(input string what);
        for (int u = 0; u < UNITS; u++) begin
            assert (root_of(u) == exp_root[u]) else
                fail_now($sformatf("[FAIL] %0t: %s, unit %0d root %0d, expected %0d",
                                   $time, what, u, root_of(u), exp_root[u]));
        end
        assert (odd_clusters_o == exp_odd) else
            fail_now($sformatf("[FAIL] %0t: %s, odd flags %h, expected %h",
                               $time, what, odd_clusters_o, exp_odd));
    endtask

    task automatic wait_ack(input bit dec, input logic level);
        int cycles;
        cycles = 0;
        while ((dec ? dec_ack_o : meas_ack_o) != level) begin
            assert (cycles < TIMEOUT) else
                fail_now($sformatf("timeout, %s never went to %0d",
                                   dec ? "dec_ack_o" : "meas_ack_o", level));
            tick();
            cycles++;
        end
    endtask

    task automatic load_round(input logic [PER_ROUND-1:0] bits);
        measurements_i = bits;
        meas_req_i     = 1'b1;
        wait_ack(1'b0, 1'b1);
        ref_meas = {bits, ref_meas[UNITS-1:PER_ROUND]};  // older round moves down
        expect_singletons();
        check_outputs("load");
        meas_req_i = 1'b0;
        wait_ack(1'b0, 1'b0);
    endtask

    task automatic run_decode(input int hold);
        model_decode();
        dec_req_i = 1'b1;
        wait_ack(1'b1, 1'b1);
        check_outputs("decode");
        repeat (hold) begin  // ack held and graph quiet
            assert (dec_ack_o === 1'b1 && busy_o == '0) else
                fail_now($sformatf("[FAIL] %0t: dec_ack_o %b busy %h with request held",
                                   $time, dec_ack_o, busy_o));
            tick();
        end
        dec_req_i = 1'b0;
        tick();
        assert (dec_ack_o === 1'b0) else
            fail_now($sformatf("[FAIL] %0t: dec_ack_o still high after request fell", $time));
    endtask

    task automatic reset_values();
        ref_meas = '0;
        expect_singletons();
        check_outputs("reset");
        assert (!meas_ack_o && !dec_ack_o && busy_o == '0) else
            fail_now($sformatf("[FAIL] %0t: acks %b %b busy %h after reset",
                               $time, meas_ack_o, dec_ack_o, busy_o));
    endtask

    task automatic row0_defect();
        int k;
        int j;
        k = int'($urandom % 2);
        j = int'($urandom % 2);
        // row 0 sits in the low bits of a round
        load_round((k == 0) ? PER_ROUND'(1 << j) : '0);
        load_round((k == 1) ? PER_ROUND'(1 << j) : '0);
        run_decode(1);
    endtask

    always @(negedge clk) begin
        assert (UUT.u_ctrl.u_asserts.error_count == 0) else
            fail_now("a bound handshake assertion fired");
    end

    initial begin
        void'($urandom(32'h7a4dd194));
        rst_i          = 1'b1;
        meas_req_i     = 1'b0;
        dec_req_i      = 1'b0;
        measurements_i = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        reset_values();
        load_round(8'hA5);  // measurement shift
        load_round(8'h3C);
        load_round('0);  // empty decode
        load_round('0);
        run_decode(1);
        load_round(8'h20);  // vertical pair at row 2 column 1
        load_round(8'h20);
        run_decode(1);
        row0_defect();
        load_round(PER_ROUND'($urandom) & PER_ROUND'($urandom));  // held handshake
        load_round(PER_ROUND'($urandom) & PER_ROUND'($urandom));
        run_decode(5);
        if (UUT.u_ctrl.u_asserts.error_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_now("a bound handshake assertion fired");
        end
    end

endmodule

`default_nettype wire

/* bench/tb_decoding_graph_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decoding_graph_asserts import dg_pkg::*; (
    input logic   clk,
    input logic   rst_i,
    input logic   meas_req_i,
    input logic   dec_req_i,
    input logic   meas_ack_i,
    input logic   dec_ack_i,
    input stage_t stage_i
);

    int unsigned error_count = 0;  // watched by the testbench top

    // an ack only rises on a request seen at the edge before
    ack_rise: assert property (@(posedge clk) disable iff (rst_i)
        (!$rose(meas_ack_i) || $past(meas_req_i)) && (!$rose(dec_ack_i) || $past(dec_req_i)))
    else begin
        $error("an ack rose without its request");
        error_count++;
    end

    // ack held with a low request must be gone one edge later
    ack_fall: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(meas_ack_i && !meas_req_i) || !meas_ack_i)
        && (!$past(dec_ack_i && !dec_req_i) || !dec_ack_i))
    else begin
        $error("an ack stayed high after its request fell");
        error_count++;
    end

    ack_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(meas_ack_i && dec_ack_i) && (!(meas_ack_i || dec_ack_i) || stage_i == STAGE_IDLE))
    else begin
        $error("both acks high, or an ack high outside the idle stage");
        error_count++;
    end

endmodule

bind stage_controller tb_decoding_graph_asserts u_asserts (
    .clk        (clk),
    .rst_i      (rst_i),
    .meas_req_i (meas_req_i),
    .dec_req_i  (dec_req_i),
    .meas_ack_i (meas_ack_o),
    .dec_ack_i  (dec_ack_o),
    .stage_i    (stage_o)
);

`default_nettype wire

/* logic/decoding_graph.sv */
`timescale 1ns/1ps
`default_nettype none

module decoding_graph import dg_pkg::*; #(
    parameter int  GRID_WIDTH_X  = 4,
    parameter int  GRID_WIDTH_Z  = 2,
    parameter int  GRID_WIDTH_U  = 2,
    parameter int  MAX_WEIGHT    = 2,
    localparam int X_BIT_WIDTH   = $clog2(GRID_WIDTH_X),
    localparam int Z_BIT_WIDTH   = $clog2(GRID_WIDTH_Z),
    localparam int U_BIT_WIDTH   = $clog2(GRID_WIDTH_U),
    localparam int ADDRESS_WIDTH = U_BIT_WIDTH + X_BIT_WIDTH + Z_BIT_WIDTH,
    localparam int PU_PER_ROUND  = GRID_WIDTH_X * GRID_WIDTH_Z,
    localparam int PU_COUNT      = PU_PER_ROUND * GRID_WIDTH_U
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic [PU_PER_ROUND-1:0]           measurements_i,
    input  logic                              meas_req_i,
    input  logic                              dec_req_i,
    output logic                              meas_ack_o,
    output logic                              dec_ack_o,
    output logic [PU_COUNT-1:0]               odd_clusters_o,
    output logic [PU_COUNT-1:0]               busy_o,
    output logic [ADDRESS_WIDTH*PU_COUNT-1:0] roots_o
);

    localparam int DATA_WIDTH = ADDRESS_WIDTH + DATA_FLAG_BITS;

    stage_t stage;
    wire [PU_COUNT-1:0]                       meas_out;  // systolic round shift
    wire [PU_COUNT-1:0]                       increase;
    wire [NEIGHBOR_COUNT-1:0]                 nb_grown     [PU_COUNT];
    wire [NEIGHBOR_COUNT-1:0]                 nb_boundary  [PU_COUNT];
    wire [NEIGHBOR_COUNT-1:0][DATA_WIDTH-1:0] data_to_pu   [PU_COUNT];
    wire [NEIGHBOR_COUNT-1:0][DATA_WIDTH-1:0] data_from_pu [PU_COUNT];

    stage_controller u_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .meas_req_i (meas_req_i),
        .dec_req_i  (dec_req_i),
        .any_busy_i (|busy_o),
        .any_odd_i  (|odd_clusters_o),
        .meas_ack_o (meas_ack_o),
        .dec_ack_o  (dec_ack_o),
        .stage_o    (stage)
    );

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : g_round
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : g_row
            for (genvar j = 0; j < GRID_WIDTH_Z; j++) begin : g_col
                localparam int UNIT = k*PU_PER_ROUND + i*GRID_WIDTH_Z + j;
                // address is round, row, column
                localparam logic [ADDRESS_WIDTH-1:0] ADDRESS = ADDRESS_WIDTH'(
                    (k << (X_BIT_WIDTH + Z_BIT_WIDTH)) | (i << Z_BIT_WIDTH) | j);
                wire meas_in;

                if (k == GRID_WIDTH_U - 1) begin : g_newest
                    assign meas_in = measurements_i[i*GRID_WIDTH_Z + j];
                end else begin : g_older
                    assign meas_in = meas_out[UNIT + PU_PER_ROUND];  // round above
                end

                processing_unit #(
                    .ADDRESS_WIDTH (ADDRESS_WIDTH),
                    .ADDRESS       (ADDRESS)
                ) u_pu (
                    .clk                    (clk),
                    .rst_i                  (rst_i),
                    .stage_i                (stage),
                    .measurement_i          (meas_in),
                    .measurement_o          (meas_out[UNIT]),
                    .increase_o             (increase[UNIT]),
                    .neighbor_fully_grown_i (nb_grown[UNIT]),
                    .neighbor_is_boundary_i (nb_boundary[UNIT]),
                    .neighbor_data_i        (data_to_pu[UNIT]),
                    .neighbor_data_o        (data_from_pu[UNIT]),
                    .odd_o                  (odd_clusters_o[UNIT]),
                    .root_o                 (roots_o[UNIT*ADDRESS_WIDTH +: ADDRESS_WIDTH]),
                    .busy_o                 (busy_o[UNIT])
                );

                for (genvar d = 0; d < NEIGHBOR_COUNT; d++) begin : g_dir
                    localparam int PK = (d == DIR_UP) ? k + 1 : (d == DIR_DOWN) ? k - 1 : k;
                    localparam int PI = (d == DIR_SOUTH) ? i + 1 : (d == DIR_NORTH) ? i - 1 : i;
                    localparam int PJ = (d == DIR_EAST) ? j + 1 : (d == DIR_WEST) ? j - 1 : j;
                    localparam bit PEER_OK = PK >= 0 && PK < GRID_WIDTH_U
                                          && PI >= 0 && PI < GRID_WIDTH_X
                                          && PJ >= 0 && PJ < GRID_WIDTH_Z;
                    // off-grid north, south and down reach the code boundary
                    localparam bit BND = !PEER_OK
                        && (d == DIR_NORTH || d == DIR_SOUTH || d == DIR_DOWN);
                    localparam int PEER = PEER_OK ? PK*PU_PER_ROUND + PI*GRID_WIDTH_Z + PJ
                                                  : UNIT;
                    localparam int PD = d ^ 1;  // peer's slot facing back

                    // internal links are built once, from the north, west or down side
                    if (BND || (PEER_OK && d % 2 == 0)) begin : g_link
                        wire                  fully_grown;
                        wire                  is_boundary;
                        wire [DATA_WIDTH-1:0] b_data;

                        neighbor_link #(
                            .MAX_WEIGHT (MAX_WEIGHT),
                            .DATA_WIDTH (DATA_WIDTH),
                            .KIND       (link_kind_t'(BND))
                        ) u_link (
                            .clk           (clk),
                            .rst_i         (rst_i),
                            .stage_i       (stage),
                            .a_increase_i  (increase[UNIT]),
                            .b_increase_i  (BND ? 1'b0 : increase[PEER]),
                            .a_data_i      (data_from_pu[UNIT][d]),
                            .b_data_i      (BND ? '0 : data_from_pu[PEER][PD]),
                            .a_data_o      (data_to_pu[UNIT][d]),
                            .b_data_o      (b_data),
                            .fully_grown_o (fully_grown),
                            .is_boundary_o (is_boundary)
                        );

                        assign nb_grown[UNIT][d]    = fully_grown;
                        assign nb_boundary[UNIT][d] = is_boundary;
                        if (!BND) begin : g_peer
                            assign data_to_pu[PEER][PD]  = b_data;
                            assign nb_grown[PEER][PD]    = fully_grown;
                            assign nb_boundary[PEER][PD] = is_boundary;
                        end
                    end else if (!PEER_OK) begin : g_none  // column edge or top round
                        assign data_to_pu[UNIT][d]  = '0;
                        assign nb_grown[UNIT][d]    = 1'b0;
                        assign nb_boundary[UNIT][d] = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/stage_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_controller import dg_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   meas_req_i,
    input  logic   dec_req_i,
    input  logic   any_busy_i,
    input  logic   any_odd_i,
    output logic   meas_ack_o,
    output logic   dec_ack_o,
    output stage_t stage_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,      // one load cycle
        S_LOAD_ACK,  // wait for meas_req_i to fall
        S_MERGE,
        S_GROW,      // one grow step
        S_DEC_ACK    // wait for dec_req_i to fall
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   merge_first_q;  // busy still reflects the cycle before merge

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                // load wins a tie, the other request just waits
                if (meas_req_i) begin
                    state_d = S_LOAD;
                end else if (dec_req_i) begin
                    state_d = S_MERGE;
                end
            end
            S_LOAD: state_d = S_LOAD_ACK;
            S_LOAD_ACK: begin
                if (!meas_req_i) state_d = S_IDLE;
            end
            S_MERGE: begin
                // settled once no unit changed for a whole cycle
                if (!merge_first_q && !any_busy_i) begin
                    state_d = any_odd_i ? S_GROW : S_DEC_ACK;
                end
            end
            S_GROW: state_d = S_MERGE;
            S_DEC_ACK: begin
                if (!dec_req_i) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q       <= S_IDLE;
            merge_first_q <= 1'b0;
            meas_ack_o    <= 1'b0;
            dec_ack_o     <= 1'b0;
        end else begin
            state_q       <= state_d;
            merge_first_q <= (state_d == S_MERGE) && (state_q != S_MERGE);
            meas_ack_o    <= (state_q == S_LOAD_ACK) && meas_req_i;  // drops with the req
            dec_ack_o     <= (state_q == S_DEC_ACK) && dec_req_i;
        end
    end

    always_comb begin
        case (state_q)
            S_LOAD:  stage_o = STAGE_LOAD;
            S_MERGE: stage_o = STAGE_MERGE;
            S_GROW:  stage_o = STAGE_GROW;
            default: stage_o = STAGE_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* logic/processing_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module processing_unit import dg_pkg::*; #(
    parameter int                       ADDRESS_WIDTH = 4,
    parameter logic [ADDRESS_WIDTH-1:0] ADDRESS       = '0
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  stage_t                    stage_i,
    input  logic                      measurement_i,
    output logic                      measurement_o,
    output logic                      increase_o,
    input  logic [NEIGHBOR_COUNT-1:0] neighbor_fully_grown_i,
    input  logic [NEIGHBOR_COUNT-1:0] neighbor_is_boundary_i,
    input  logic [NEIGHBOR_COUNT*(ADDRESS_WIDTH+DATA_FLAG_BITS)-1:0] neighbor_data_i,
    output logic [NEIGHBOR_COUNT*(ADDRESS_WIDTH+DATA_FLAG_BITS)-1:0] neighbor_data_o,
    output logic                      odd_o,
    output logic [ADDRESS_WIDTH-1:0]  root_o,
    output logic                      busy_o
);

    localparam int DATA_WIDTH = ADDRESS_WIDTH + DATA_FLAG_BITS;

    logic                      defect_q;    // own measurement, also shifts down
    logic [ADDRESS_WIDTH-1:0]  root_q;
    logic [NEIGHBOR_COUNT-1:0] parent_q;    // one-hot, zero on a cluster root
    logic                      parity_q;
    logic                      boundary_q;
    logic                      odd_q;
    logic                      busy_q;

    logic [ADDRESS_WIDTH-1:0]  root_d;
    logic [NEIGHBOR_COUNT-1:0] parent_d;
    logic                      parity_d;
    logic                      boundary_d;
    logic                      odd_d;
    logic                      parent_odd;
    logic                      changed;

    always_comb begin
        logic [DATA_WIDTH-1:0]    word;
        logic [ADDRESS_WIDTH-1:0] nb_root;
        root_d     = root_q;
        parent_d   = parent_q;
        parity_d   = defect_q;
        boundary_d = 1'b0;
        parent_odd = 1'b0;
        for (int d = 0; d < NEIGHBOR_COUNT; d++) begin
            word    = neighbor_data_i[d*DATA_WIDTH +: DATA_WIDTH];
            nb_root = word[DATA_WIDTH-1 -: ADDRESS_WIDTH];
            // only a strictly lower root moves the parent, so pointers never loop
            if (neighbor_fully_grown_i[d] && !neighbor_is_boundary_i[d]
                    && nb_root < root_d) begin
                root_d   = nb_root;
                parent_d = NEIGHBOR_COUNT'(1) << d;
            end
            if (word[FLD_PARENT]) begin  // a child reporting its subtree
                parity_d   = parity_d ^ word[FLD_PARITY];
                boundary_d = boundary_d | word[FLD_BOUNDARY];
            end
            boundary_d = boundary_d | neighbor_is_boundary_i[d];
            if (parent_q[d]) parent_odd = word[FLD_ODD];
        end
        // root decides, everyone else follows the parent
        odd_d = (parent_q == '0) ? (parity_q & ~boundary_q) : parent_odd;
    end

    assign changed = (root_d != root_q) || (parent_d != parent_q)
                  || (parity_d != parity_q) || (boundary_d != boundary_q)
                  || (odd_d != odd_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            defect_q   <= 1'b0;
            root_q     <= ADDRESS;
            parent_q   <= '0;
            parity_q   <= 1'b0;
            boundary_q <= 1'b0;
            odd_q      <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            busy_q <= 1'b0;
            case (stage_i)
                STAGE_LOAD: begin  // singleton cluster around the new measurement
                    defect_q   <= measurement_i;
                    root_q     <= ADDRESS;
                    parent_q   <= '0;
                    parity_q   <= measurement_i;
                    boundary_q <= 1'b0;
                    odd_q      <= measurement_i;
                end
                STAGE_MERGE: begin
                    root_q     <= root_d;
                    parent_q   <= parent_d;
                    parity_q   <= parity_d;
                    boundary_q <= boundary_d;
                    odd_q      <= odd_d;
                    busy_q     <= changed;  // seen by the controller a cycle later
                end
                default: begin
                end
            endcase
        end
    end

    // same word on every side except the parent flag
    always_comb begin
        for (int d = 0; d < NEIGHBOR_COUNT; d++) begin
            neighbor_data_o[d*DATA_WIDTH +: DATA_WIDTH] =
                {root_q, parent_q[d], parity_q, boundary_q, odd_q};
        end
    end

    assign measurement_o = defect_q;
    assign increase_o    = (stage_i == STAGE_GROW) && odd_q;
    assign odd_o         = odd_q;
    assign root_o        = root_q;
    assign busy_o        = busy_q;

endmodule

`default_nettype wire

/* logic/neighbor_link.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_link import dg_pkg::*; #(
    parameter int         MAX_WEIGHT = 2,
    parameter int         DATA_WIDTH = 8,
    parameter link_kind_t KIND       = LINK_INTERNAL
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  stage_t                stage_i,
    input  logic                  a_increase_i,
    input  logic                  b_increase_i,
    input  logic [DATA_WIDTH-1:0] a_data_i,
    input  logic [DATA_WIDTH-1:0] b_data_i,
    output logic [DATA_WIDTH-1:0] a_data_o,
    output logic [DATA_WIDTH-1:0] b_data_o,
    output logic                  fully_grown_o,
    output logic                  is_boundary_o
);

    localparam int GROWTH_WIDTH = $clog2(MAX_WEIGHT + 1);
    localparam logic [GROWTH_WIDTH:0] WEIGHT = (GROWTH_WIDTH + 1)'(MAX_WEIGHT);

    logic [GROWTH_WIDTH-1:0] growth_q;
    logic [GROWTH_WIDTH:0]   growth_sum;  // spare bit, both sides may push at once

    assign growth_sum = {1'b0, growth_q}
                      + {{GROWTH_WIDTH{1'b0}}, a_increase_i}
                      + {{GROWTH_WIDTH{1'b0}}, b_increase_i};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            growth_q <= '0;
        end else if (stage_i == STAGE_LOAD) begin
            growth_q <= '0;  // new round, every link starts empty
        end else if (stage_i == STAGE_GROW) begin
            // saturate at the link weight
            if (growth_sum >= WEIGHT) begin
                growth_q <= WEIGHT[GROWTH_WIDTH-1:0];
            end else begin
                growth_q <= growth_sum[GROWTH_WIDTH-1:0];
            end
        end
    end

    assign fully_grown_o = ({1'b0, growth_q} == WEIGHT);

    // words cross only over a full internal link, zeros otherwise
    assign a_data_o = (fully_grown_o && KIND == LINK_INTERNAL) ? b_data_i : '0;
    assign b_data_o = (fully_grown_o && KIND == LINK_INTERNAL) ? a_data_i : '0;

    assign is_boundary_o = fully_grown_o && (KIND == LINK_BOUNDARY);

endmodule

`default_nettype wire

/* logic/dg_pkg.sv */
`default_nettype none

package dg_pkg;

    // global stage, broadcast to every unit and link
    typedef enum logic [1:0] {
        STAGE_IDLE  = 2'd0,
        STAGE_LOAD  = 2'd1,  // shift a measurement round in
        STAGE_GROW  = 2'd2,  // odd clusters grow one step
        STAGE_MERGE = 2'd3   // roots and parities settle
    } stage_t;

    typedef enum logic {
        LINK_INTERNAL = 1'b0,  // unit to unit
        LINK_BOUNDARY = 1'b1   // unit to code edge
    } link_kind_t;

    localparam int NEIGHBOR_COUNT = 6;

    // opposite slots differ only in bit 0
    localparam int DIR_NORTH = 0;
    localparam int DIR_SOUTH = 1;
    localparam int DIR_WEST  = 2;
    localparam int DIR_EAST  = 3;
    localparam int DIR_DOWN  = 4;
    localparam int DIR_UP    = 5;

    // exposed word: root on top of these flag bits
    localparam int DATA_FLAG_BITS = 4;
    localparam int FLD_ODD        = 0;
    localparam int FLD_BOUNDARY   = 1;  // subtree touches a boundary
    localparam int FLD_PARITY     = 2;  // subtree defect parity
    localparam int FLD_PARENT     = 3;  // sender names the receiver as parent

endpackage

`default_nettype wire
